// ==== rtl/nn_cfg_pkg.sv ====
`default_nettype none

package nn_cfg_pkg;

    // vector sizing
    localparam int neuron_num  = 4;  // neurons in the output layer
    localparam int z_width     = 8;  // signed pre-activation
    localparam int act_width   = 8;  // unsigned activation / target

    // arithmetic widths
    localparam int der_width   = 9;  // derivative, padded to diff width
    localparam int diff_width  = 9;  // signed a - y
    localparam int delta_width = 18; // signed (a - y) * a'

    localparam int tag_width   = 8;  // sample tag carried alongside
    localparam int lut_depth   = 256; // one entry per value of z

    // which rule fills a lookup table
    typedef enum logic [0:0] {
        lut_act, // hard sigmoid activation
        lut_der  // derivative taken from that activation
    } lut_kind_e;

endpackage

`default_nettype wire

// ==== rtl/nn_delta_pkg.sv ====
`default_nettype none

package nn_delta_pkg;

    // scalar element types
    typedef logic signed [nn_cfg_pkg::z_width-1:0]     z_t;
    typedef logic        [nn_cfg_pkg::act_width-1:0]   act_t;   // also used for targets
    typedef logic        [nn_cfg_pkg::der_width-1:0]   der_t;   // msb always zero
    typedef logic signed [nn_cfg_pkg::delta_width-1:0] delta_t;

    // one element per neuron, lane 0 in the low bits
    typedef z_t     [nn_cfg_pkg::neuron_num-1:0] z_vec_t;
    typedef act_t   [nn_cfg_pkg::neuron_num-1:0] act_vec_t;
    typedef der_t   [nn_cfg_pkg::neuron_num-1:0] der_vec_t;
    typedef delta_t [nn_cfg_pkg::neuron_num-1:0] delta_vec_t;

    // request: tag, pre-activations and targets
    typedef struct packed {
        logic [nn_cfg_pkg::tag_width-1:0] tag;
        z_vec_t                           z;
        act_vec_t                         y;
    } delta_req_t;

    // response: tag echoed back with the delta vector
    typedef struct packed {
        logic [nn_cfg_pkg::tag_width-1:0] tag;
        delta_vec_t                       delta;
    } delta_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/activation_lut.sv ====
`timescale 1ns/1ps
`default_nettype none

module activation_lut #(
    parameter type                   entry_t = nn_delta_pkg::act_t,
    parameter nn_cfg_pkg::lut_kind_e kind    = nn_cfg_pkg::lut_act
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  en,
    input  nn_delta_pkg::z_vec_t                  z,
    output entry_t [nn_cfg_pkg::neuron_num-1:0]   entries
);

    typedef entry_t table_t [nn_cfg_pkg::lut_depth];

    // entry for a table index, the index being z read as unsigned
    function automatic entry_t lut_rule(int idx);
        int z_val;
        int a_val;
        z_val = (idx >= nn_cfg_pkg::lut_depth / 2) ? idx - nn_cfg_pkg::lut_depth : idx;
        a_val = 2 * z_val + 128; // hard sigmoid before clamping
        if (a_val < 0) begin
            a_val = 0;
        end else if (a_val > 255) begin
            a_val = 255;
        end
        if (kind == nn_cfg_pkg::lut_act) begin
            return entry_t'(a_val);
        end
        return entry_t'((a_val * (255 - a_val)) / 256); // a' = a(1-a) in 8-bit scale
    endfunction

    function automatic table_t build_table();
        table_t t;
        for (int i = 0; i < nn_cfg_pkg::lut_depth; i++) begin
            t[i] = lut_rule(i);
        end
        return t;
    endfunction

    localparam table_t lut_table = build_table(); // fixed at elaboration

    // four lanes read the same table in parallel
    always_ff @(posedge clk) begin
        if (rst) begin
            entries <= '0;
        end else if (en) begin // hold while the pipeline is stalled
            for (int i = 0; i < nn_cfg_pkg::neuron_num; i++) begin
                entries[i] <= lut_table[$unsigned(z[i])]; // -1 maps to entry 255
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/delta_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module delta_combiner (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,
    input  logic [nn_cfg_pkg::tag_width-1:0] tag,
    input  nn_delta_pkg::act_vec_t           y,
    input  nn_delta_pkg::act_vec_t           act,   // registered by the lookup
    input  nn_delta_pkg::der_vec_t           der,   // registered by the lookup
    output logic                             advance,
    output nn_delta_pkg::delta_rsp_t         rsp,
    output logic                             rsp_valid,
    input  logic                             rsp_ready
);

    typedef logic signed [nn_cfg_pkg::diff_width-1:0] diff_t;
    typedef diff_t [nn_cfg_pkg::neuron_num-1:0]       diff_vec_t;

    // stage 1, alongside the lookup registers
    logic                             s1_valid;
    logic [nn_cfg_pkg::tag_width-1:0] s1_tag;
    nn_delta_pkg::act_vec_t           s1_y;

    // stage 2, difference and carried derivative
    logic                             s2_valid;
    logic [nn_cfg_pkg::tag_width-1:0] s2_tag;
    diff_vec_t                        s2_diff;
    nn_delta_pkg::der_vec_t           s2_der;

    // stage 3 is the response register itself
    logic                             s3_valid;

    // the whole pipe moves together, so one stall signal is enough
    assign advance   = !s3_valid || rsp_ready;
    assign rsp_valid = s3_valid;

    // valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid; // req_ready is advance, so this is the handshake
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // stage 1: capture tag and target with the lookup inputs
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_tag <= tag;
            s1_y   <= y;
        end
    end

    // stage 2: a - y, both zero-extended so the result is signed 9 bits
    always_ff @(posedge clk) begin
        if (advance) begin
            s2_tag <= s1_tag;
            s2_der <= der;
            for (int i = 0; i < nn_cfg_pkg::neuron_num; i++) begin
                s2_diff[i] <= $signed({1'b0, act[i]}) - $signed({1'b0, s1_y[i]});
            end
        end
    end

    // stage 3: signed product, a' has a zero msb so it stays positive
    always_ff @(posedge clk) begin
        if (advance) begin
            rsp.tag <= s2_tag;
            for (int i = 0; i < nn_cfg_pkg::neuron_num; i++) begin
                rsp.delta[i] <= nn_delta_pkg::delta_t'(s2_diff[i] * $signed(s2_der[i]));
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/output_delta_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_delta_top (
    input  logic                     clk,
    input  logic                     rst,
    input  nn_delta_pkg::delta_req_t req,
    input  logic                     req_valid,
    output logic                     req_ready,
    output nn_delta_pkg::delta_rsp_t rsp,
    output logic                     rsp_valid,
    input  logic                     rsp_ready
);

    logic                   advance; // pipeline moves on this cycle
    nn_delta_pkg::act_vec_t act;     // a per lane, stage 1
    nn_delta_pkg::der_vec_t der;     // a' per lane, stage 1

    assign req_ready = advance;

    // activation table
    activation_lut #(
        .entry_t (nn_delta_pkg::act_t),
        .kind    (nn_cfg_pkg::lut_act)
    ) act_lut (
        .clk     (clk),
        .rst     (rst),
        .en      (advance),
        .z       (req.z),
        .entries (act)
    );

    // derivative table, padded to the difference width
    activation_lut #(
        .entry_t (nn_delta_pkg::der_t),
        .kind    (nn_cfg_pkg::lut_der)
    ) der_lut (
        .clk     (clk),
        .rst     (rst),
        .en      (advance),
        .z       (req.z),
        .entries (der)
    );

    delta_combiner combiner (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .tag       (req.tag),
        .y         (req.y),
        .act       (act),
        .der       (der),
        .advance   (advance),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

endmodule

`default_nettype wire

// ==== verif/delta_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module delta_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_ready,
    input  nn_delta_pkg::delta_rsp_t rsp,
    input  logic                     rsp_valid,
    input  logic                     rsp_ready
);

    nn_delta_pkg::delta_rsp_t exp_q[$];   // expected responses in order
    int                       adv_q[$];   // pipeline moves seen at acceptance
    int                       adv_count    = 0;
    logic                     held         = 1'b0; // response shown but not taken
    nn_delta_pkg::delta_rsp_t held_rsp;
    int                       test_errors  = 0;
    int                       test_checked = 0;
    int                       err_total    = 0;
    int                       pass_count   = 0;
    int                       fail_count   = 0;

    task automatic value_error(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] expected);
        $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, expected);
        test_errors++;
        err_total++;
    endtask

    task automatic word_error(input string msg);
        $display("at %0t: %s", $time, msg);
        test_errors++;
        err_total++;
    endtask

    // called by the testbench on every accepted request
    task automatic expect_rsp(input nn_delta_pkg::delta_rsp_t exp);
        exp_q.push_back(exp);
        adv_q.push_back(adv_count); // count before the accepting edge
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_idle();
        if (rsp_valid !== 1'b0) begin
            value_error("rsp_valid", rsp_valid, 0);
        end
        if (req_ready !== 1'b1) begin
            value_error("req_ready", req_ready, 1);
        end
    endtask

    // three pipeline moves from acceptance to a visible response
    task automatic check_latency();
        if (adv_q.size() > 0 && adv_count - adv_q[0] != 3) begin
            word_error($sformatf("response tag %0d appeared after %0d pipeline moves, not 3",
                                 rsp.tag, adv_count - adv_q[0]));
        end
    endtask

    task automatic compare_head();
        nn_delta_pkg::delta_rsp_t exp;
        if (exp_q.size() == 0) begin
            word_error($sformatf("extra response with tag %0d, none was outstanding", rsp.tag));
        end else begin
            exp = exp_q.pop_front();
            void'(adv_q.pop_front());
            test_checked++;
            if (rsp.tag !== exp.tag) begin
                value_error("rsp.tag", rsp.tag, exp.tag);
            end
            for (int i = 0; i < nn_cfg_pkg::neuron_num; i++) begin
                if (rsp.delta[i] !== exp.delta[i]) begin
                    value_error($sformatf("rsp.delta[%0d]", i), rsp.delta[i], exp.delta[i]);
                end
            end
        end
    endtask

    task automatic report_test(input int num);
        if (test_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s: %0d responses checked, %0d errors", num,
                 (test_errors == 0) ? "passed" : "failed", test_checked, test_errors);
        test_errors  = 0;
        test_checked = 0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            adv_count <= 0;
            held      <= 1'b0;
        end else begin
            if (held) begin
                if (rsp_valid !== 1'b1) begin
                    word_error("rsp_valid dropped while rsp_ready was low");
                end else if (rsp !== held_rsp) begin
                    word_error($sformatf("rsp changed while stalled, tag %0d", rsp.tag));
                end
            end else if (rsp_valid === 1'b1) begin
                check_latency(); // first cycle this response is shown
            end
            // a stalled output freezes the whole pipe
            if (rsp_valid === 1'b1 && rsp_ready === 1'b0 && req_ready !== 1'b0) begin
                value_error("req_ready", req_ready, 0);
            end
            if (rsp_valid === 1'b1 && rsp_ready === 1'b1) begin
                compare_head();
            end
            adv_count <= adv_count + (req_ready ? 1 : 0);
            held      <= rsp_valid && !rsp_ready;
            held_rsp  <= rsp;
        end
    end

endmodule

`default_nettype wire

// ==== verif/output_delta_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_delta_tb;

    localparam int max_lines = 64;
    typedef logic [nn_cfg_pkg::tag_width-1:0] tag_t;

    logic                     clk;
    logic                     rst;
    nn_delta_pkg::delta_req_t req;
    logic                     req_valid;
    logic                     req_ready;
    nn_delta_pkg::delta_rsp_t rsp;
    logic                     rsp_valid;
    logic                     rsp_ready;

    int stall_q[$];                  // rsp_ready low cycles, one per response
    int trace_row [max_lines][15];   // test, tag, z x4, y x4, delta x4, stall
    int line_count  = 0;
    int cycle_limit = 0;
    int cycle_count = 0;

    output_delta_top output_delta_top_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    delta_checker checker_i (
        .clk       (clk),
        .rst       (rst),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d responses never arrived",
                     cycle_count, checker_i.pending());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic read_trace();
        int    fd;
        int    cnt;
        string line;
        int    f [15];
        fd = $fopen("verif/output_delta_trace.txt", "r");
        if (fd == 0) begin
            checker_i.word_error("could not open verif/output_delta_trace.txt");
        end else begin
            while (!$feof(fd) && line_count < max_lines) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                  f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                    if (cnt == 15) begin
                        trace_row[line_count] = f;
                        line_count++;
                    end
                end
            end
            $fclose(fd);
            if (line_count == 0) begin
                checker_i.word_error("no requests found in verif/output_delta_trace.txt");
            end
        end
    endtask

    task automatic send_request(input int n);
        nn_delta_pkg::delta_rsp_t exp;
        @(negedge clk);
        req.tag = tag_t'(trace_row[n][1]);
        for (int i = 0; i < nn_cfg_pkg::neuron_num; i++) begin
            req.z[i] = nn_delta_pkg::z_t'(trace_row[n][2 + i]);
            req.y[i] = nn_delta_pkg::act_t'(trace_row[n][6 + i]);
        end
        req_valid = 1'b1;
        do @(posedge clk); while (req_ready !== 1'b1); // held until the handshake
        exp.tag = req.tag;
        for (int i = 0; i < nn_cfg_pkg::neuron_num; i++) begin
            exp.delta[i] = nn_delta_pkg::delta_t'(trace_row[n][10 + i]);
        end
        checker_i.expect_rsp(exp);
        stall_q.push_back(trace_row[n][14]);
    endtask

    // back-pressure, rsp_ready drops for the traced count once a response shows
    initial begin
        int stall;
        rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (rsp_valid === 1'b1 && stall_q.size() > 0) begin
                stall = stall_q.pop_front();
                if (stall > 0) begin
                    rsp_ready = 1'b0;
                    repeat (stall) @(negedge clk);
                    rsp_ready = 1'b1;
                end
                @(posedge clk); // taken on this edge
            end
        end
    end

    initial begin
        int unsigned seed;
        int          n;
        int          cur;
        int          gap;
        seed = 32'hd4da;
        void'($urandom(seed));
        rst       = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        read_trace();
        cycle_limit = 20 * line_count + 200;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        checker_i.check_idle(); // empty pipeline after reset
        checker_i.report_test(1);
        n = 0;
        while (n < line_count) begin
            cur = trace_row[n][0];
            gap = $urandom % 4; // idle cycles before each test
            repeat (gap) @(negedge clk);
            while (n < line_count && trace_row[n][0] == cur) begin
                send_request(n);
                n++;
            end
            @(negedge clk);
            req_valid = 1'b0;
            while (checker_i.pending() != 0) begin
                @(negedge clk);
            end
            checker_i.report_test(cur);
        end
        $display("summary: %0d tests passed, %0d tests failed",
                 checker_i.pass_count, checker_i.fail_count);
        if (checker_i.fail_count == 0 && checker_i.err_total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== nn_delta.f ====
rtl/nn_cfg_pkg.sv
rtl/nn_delta_pkg.sv
rtl/activation_lut.sv
rtl/delta_combiner.sv
rtl/output_delta_top.sv
verif/delta_checker.sv
verif/output_delta_tb.sv

// ==== verif/output_delta_trace.txt ====
# test tag z0 z1 z2 z3 y0 y1 y2 y3 delta0 delta1 delta2 delta3 stall
# decimal, lane 0 first; stall is the number of cycles rsp_ready stays low once shown
# test 2: single request
2 1 0 10 -10 20 100 150 100 200 1764 -122 496 -1824 0
# test 3: saturation, alone and mixed with active lanes
3 2 -64 64 -128 127 0 255 255 0 0 0 0 0 0
3 3 -100 100 -65 65 37 200 255 12 0 0 0 0 0
3 4 -64 0 64 -63 50 50 50 50 0 4914 0 -48 0
3 5 63 127 -62 62 0 0 255 255 0 0 -753 -6 0
# test 4: target above activation gives negative deltas
4 6 -30 -20 -40 -50 255 255 255 255 -9163 -9519 -7866 -5448 0
4 7 0 0 -1 1 255 0 255 0 -8001 8064 -8127 8190 0
4 8 -60 -45 -25 -15 200 100 90 99 -1344 -1984 -636 -60 0
# test 5: back-to-back with rsp_ready high
5 16 5 -5 15 -15 138 118 158 98 0 0 0 0 0
5 17 25 -25 45 -45 0 0 0 0 9434 4134 6758 1216 0
5 18 30 40 50 60 10 20 30 40 8722 7144 4752 1248 0
5 19 -10 -20 -30 -40 108 90 60 50 0 -114 392 -76 0
5 20 1 -1 62 -62 128 128 128 128 126 -126 248 -372 0
5 21 20 10 0 -10 168 148 128 108 0 0 0 0 0
5 22 63 -63 60 -60 1 1 250 9 0 1 -12 -7 0
# test 6: output stalls fill the pipeline
6 32 0 10 20 30 0 0 0 0 8064 9028 9576 9212 5
6 33 -10 -20 -30 -40 255 255 255 255 -9114 -9519 -9163 -7866 0
6 34 40 50 60 -50 100 100 100 100 4104 3072 888 -1728 3
6 35 15 -15 25 -25 255 0 255 0 -5723 5880 -4081 4134 1
6 36 45 -45 5 -5 0 255 0 255 6758 -6944 8694 -8631 7
6 37 64 -64 0 0 9 9 9 9 0 0 7497 7497 2
6 38 0 0 0 0 128 128 128 128 0 0 0 0 0
6 39 60 -60 30 -30 0 255 68 188 1488 -1729 5880 -5880 4
